// ==== filelist.f ====
hdl/core_glue_pkg.sv
hdl/status_decode.sv
hdl/sd_activity.sv
hdl/tape_control.sv
hdl/video_scaling.sv
hdl/osd_menu_mask.sv
hdl/core_glue.sv
bench/core_glue_asserts.sv
bench/core_glue_tb.sv

// ==== Bender.yml ====
package:
  name: core_glue

sources:
  - hdl/core_glue_pkg.sv
  - hdl/status_decode.sv
  - hdl/sd_activity.sv
  - hdl/tape_control.sv
  - hdl/video_scaling.sv
  - hdl/osd_menu_mask.sv
  - hdl/core_glue.sv
  - target: simulation
    files:
      - bench/core_glue_asserts.sv
      - bench/core_glue_tb.sv

// ==== bench/core_glue_tb.sv ====
/* Directed testbench for the core glue top level. Inputs change on the
   falling clock edge, outputs are checked one falling edge later */
`timescale 1ns/1ps
`default_nettype none

module core_glue_tb;
   import core_glue_pkg::*;

   logic                      clock_bus = 1'b0;
   logic                      rst;
   logic [status_width-1:0]   status;
   logic                      upload_reset, img_mounted_sd, fdc_enable;
   logic                      core_hard_reset, core_reset, sram_save, sram_load;
   logic [63:0]               img_size;
   logic                      sd_sck_core, sd_mosi_core, sd_miso_pin, vsd_miso;
   logic                      sd_miso_core, sd_cs, sd_sck, sd_mosi, led_user;
   logic [1:0]                led_disk;
   logic                      ioctl_download, motor, cas_dout, tape_adc, tape_adc_act;
   logic [15:0]               ioctl_index;
   logic [ddr_addr_width-1:0] ddr_addr_download, ddr_addr_cas, ddr_addr;
   logic                      ddr_rd_download, ddr_request_download, ddr_rd_cas, ddr_rd;
   logic                      tape_in, play, rewind, cas_enable;
   logic                      forced_scandoubler, scandoubler, hq2x;
   logic [11:0]               hdmi_width, hdmi_height, arx, ary, crop_size;
   logic [1:0]                vga_sl;
   logic [2:0]                scale;
   logic                      ocm_mode, rom_a_load_hide, rom_b_load_hide, info_req;
   logic [3:0]                cart_a_type;
   logic [5:0]                fdd_present;
   logic [15:0]               sram_size_0, sram_size_1, sram_size_2, sram_size_3;
   logic [7:0]                error_code, info;
   logic [15:0]               menu_mask;
   int unsigned               seed;

   core_glue dut0 (.*);

   always #2 clock_bus = ~clock_bus;

   // ====================
   // Helpers
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic next_cycle(input int n);
      repeat (n) @(negedge clock_bus);
   endtask

   // ====================
   // Tests
   task automatic test_reset_sources();
      int i;
      check("core_reset", core_reset, 1'b0);
      rst = 1'b1;
      next_cycle(1);
      check("core_hard_reset", core_hard_reset, 1'b1);
      check("core_reset", core_reset, 1'b1);
      rst = 1'b0;
      status[st_reset] = 1'b1;
      next_cycle(1);
      check("core_hard_reset", core_hard_reset, 1'b1);
      check("core_reset", core_reset, 1'b1);
      status[st_reset] = 1'b0;
      upload_reset = 1'b1;
      next_cycle(1);
      check("core_hard_reset", core_hard_reset, 1'b1);
      check("core_reset", core_reset, 1'b1);
      upload_reset = 1'b0;
      status[st_detach] = 1'b1;
      next_cycle(1);
      check("core_hard_reset", core_hard_reset, 1'b0);
      check("core_reset", core_reset, 1'b1);
      status[st_detach] = 1'b0;
      status[st_reset_osd] = 1'b1;
      next_cycle(1);
      check("core_hard_reset", core_hard_reset, 1'b0);
      check("core_reset", core_reset, 1'b1);
      status[st_reset_osd] = 1'b0;
      // Mount reset needs option, mount strobe and floppy controller
      for (i = 0; i < 8; i++) begin
         status[st_reset_mount] = i[2];
         img_mounted_sd = i[1];
         fdc_enable = i[0];
         next_cycle(1);
         check("core_hard_reset", core_hard_reset, 1'b0);
         check("core_reset", core_reset, i == 7);
      end
      status[st_reset_mount] = 1'b0;
      img_mounted_sd = 1'b0;
      fdc_enable = 1'b0;
      // Save and load requests come straight from the status word
      status[st_sram_save] = 1'b1;
      next_cycle(1);
      check("sram_save", sram_save, 1'b1);
      check("sram_load", sram_load, 1'b0);
      check("core_reset", core_reset, 1'b0);
      status[st_sram_save] = 1'b0;
      status[st_sram_load] = 1'b1;
      next_cycle(1);
      check("sram_save", sram_save, 1'b0);
      check("sram_load", sram_load, 1'b1);
      check("core_reset", core_reset, 1'b0);
      status[st_sram_load] = 1'b0;
      next_cycle(1);
   endtask

   task automatic test_video_scaling();
      int a;
      int s;
      for (a = 0; a < 4; a++) begin
         for (s = 0; s < 8; s++) begin
            status[st_ar_lo +: 2] = a[1:0];
            status[st_scaler_lo +: 3] = s[2:0];
            status[st_scale_lo +: 3] = 3'(7 - s);
            next_cycle(1);
            check("arx", arx, (a == 0) ? 4 : a - 1);
            check("ary", ary, (a == 0) ? 3 : 0);
            check("vga_sl", vga_sl, (s == 0) ? 0 : (s - 1) % 4);
            check("scandoubler", scandoubler, s != 0);
            check("hq2x", hq2x, s == 1);
            check("scale", scale, 7 - s);
         end
      end
      status[st_scaler_lo +: 3] = 3'd0;
      forced_scandoubler = 1'b1;
      next_cycle(1);
      check("scandoubler", scandoubler, 1'b1);
      hdmi_width = 12'd1920;
      hdmi_height = 12'd1080;
      next_cycle(2);
      check("crop_size", crop_size, 0);
      forced_scandoubler = 1'b0;
      next_cycle(1);
      check("crop_size", crop_size, 216);
      hdmi_width = 12'd1280;
      next_cycle(1);
      check("crop_size", crop_size, 0);
   endtask

   task automatic test_sd_routing();
      int n;
      img_size = {$urandom(), $urandom()};
      if (img_size == 64'd0) begin
         img_size = 64'd1;
      end
      img_mounted_sd = 1'b1;
      next_cycle(1);
      // Selection holds once the mount strobe is gone
      img_mounted_sd = 1'b0;
      img_size = 64'd0;
      sd_sck_core = 1'b1;
      sd_mosi_core = 1'b1;
      sd_miso_pin = 1'b1;
      vsd_miso = 1'b0;
      next_cycle(1);
      check("sd_cs", sd_cs, 1'b1);
      check("sd_sck", sd_sck, 1'b0);
      check("sd_mosi", sd_mosi, 1'b0);
      check("sd_miso_core", sd_miso_core, 1'b0);
      vsd_miso = 1'b1;
      next_cycle(1);
      check("sd_miso_core", sd_miso_core, 1'b1);
      sd_mosi_core = 1'b0;
      n = 0;
      while (led_user !== 1'b1 && n < 8) begin
         next_cycle(1);
         n++;
      end
      if (led_user !== 1'b1) begin
         stop_run("led_user did not light after SD activity");
      end
      check("led_disk", led_disk, 2'b10);
      n = 0;
      while (led_user !== 1'b0 && n < sd_act_cycles + 10) begin
         next_cycle(1);
         n++;
      end
      if (led_user !== 1'b0) begin
         stop_run("led_user stayed lit past the activity window");
      end
      if (n < sd_act_cycles - 10) begin
         stop_run("led_user went dark before the activity window ended");
      end
      // Empty image falls back to the physical card
      img_mounted_sd = 1'b1;
      next_cycle(1);
      img_mounted_sd = 1'b0;
      sd_miso_pin = 1'b0;
      sd_mosi_core = 1'b1;
      next_cycle(1);
      check("sd_cs", sd_cs, 1'b0);
      check("sd_sck", sd_sck, 1'b1);
      check("sd_mosi", sd_mosi, 1'b1);
      check("sd_miso_core", sd_miso_core, 1'b0);
      sd_miso_pin = 1'b1;
      next_cycle(1);
      check("sd_miso_core", sd_miso_core, 1'b1);
      n = 0;
      while (led_disk !== 2'b11 && n < 8) begin
         next_cycle(1);
         n++;
      end
      if (led_disk !== 2'b11) begin
         stop_run("disk LED did not light for physical card activity");
      end
      check("led_user", led_user, 1'b0);
   endtask

   task automatic test_cassette();
      int n;
      int i;
      check("cas_enable", cas_enable, 1'b0);
      ioctl_index = 16'h0003;
      ioctl_download = 1'b1;
      next_cycle(1);
      check("rewind", rewind, 1'b0);
      ioctl_download = 1'b0;
      next_cycle(2);
      check("cas_enable", cas_enable, 1'b0);
      // Index 0xc5 has 5 in its low six bits
      ioctl_index = 16'h00c5;
      ioctl_download = 1'b1;
      next_cycle(3);
      check("rewind", rewind, 1'b1);
      check("cas_enable", cas_enable, 1'b0);
      ioctl_download = 1'b0;
      n = 0;
      while (cas_enable !== 1'b1 && n < 4) begin
         next_cycle(1);
         n++;
      end
      if (cas_enable !== 1'b1) begin
         stop_run("cas_enable did not rise after the cassette download");
      end
      check("rewind", rewind, 1'b0);
      check("play", play, 1'b0);
      motor = 1'b0;
      next_cycle(1);
      check("play", play, 1'b1);
      motor = 1'b1;
      status[st_tape_rewind] = 1'b1;
      next_cycle(1);
      check("play", play, 1'b0);
      check("rewind", rewind, 1'b1);
      status[st_tape_rewind] = 1'b0;
      upload_reset = 1'b1;
      next_cycle(1);
      check("rewind", rewind, 1'b1);
      upload_reset = 1'b0;
      // Tape source, player output then ADC level
      cas_dout = 1'b1;
      next_cycle(1);
      check("tape_in", tape_in, 1'b1);
      status[st_tape_adc] = 1'b1;
      for (i = 0; i < 4; i++) begin
         tape_adc = i[1];
         tape_adc_act = i[0];
         cas_dout = (i != 3);
         next_cycle(1);
         check("tape_in", tape_in, i == 3);
      end
      status[st_tape_adc] = 1'b0;
      ddr_addr_download = 28'h0a51234;
      ddr_rd_download = 1'b1;
      ddr_addr_cas = 28'h35c8765;
      ddr_rd_cas = 1'b0;
      ddr_request_download = 1'b1;
      next_cycle(1);
      check("ddr_addr", ddr_addr, 28'h0a51234);
      check("ddr_rd", ddr_rd, 1'b1);
      ddr_request_download = 1'b0;
      next_cycle(1);
      check("ddr_addr", ddr_addr, 28'h35c8765);
      check("ddr_rd", ddr_rd, 1'b0);
   endtask

   task automatic test_menu_mask();
      int i;
      logic [31:0] total;
      logic [15:0] exp_mask;
      for (i = 0; i < 9; i++) begin
         sram_size_0 = (i % 3 == 0) ? 16'd0 : 16'($urandom());
         sram_size_1 = (i % 3 == 0) ? 16'd0 : 16'($urandom());
         sram_size_2 = (i % 3 == 0) ? 16'd0 : 16'($urandom());
         sram_size_3 = (i % 3 == 0) ? 16'd0 : 16'($urandom());
         ocm_mode = 1'($urandom());
         cart_a_type = (i == 2 || i == 7) ? cart_type_mfrsd : 4'($urandom());
         rom_a_load_hide = 1'($urandom());
         rom_b_load_hide = 1'($urandom());
         fdd_present = 6'($urandom());
         status[st_tape_adc] = i[0];
         error_code = (i % 2 == 0) ? 8'd0 : (8'($urandom()) | 8'd1);
         total = sram_size_0 + sram_size_1 + sram_size_2 + sram_size_3;
         exp_mask = 16'd0;
         exp_mask[0] = ocm_mode | (cart_a_type == cart_type_mfrsd);
         exp_mask[1] = rom_a_load_hide | ocm_mode;
         exp_mask[2] = rom_b_load_hide | ocm_mode;
         exp_mask[3] = ocm_mode;
         exp_mask[9:4] = fdd_present;
         exp_mask[10] = (total == 32'd0);
         exp_mask[11] = i[0];
         next_cycle(1);
         check("menu_mask", menu_mask, exp_mask);
         check("info", info, error_code);
         check("info_req", info_req, error_code != 8'd0);
      end
   endtask

   // ====================
   // Main sequence
   initial begin
      seed = $urandom(32'ha9eeb76a);
      rst = 1'b1;
      status = '0;
      upload_reset = 1'b0;
      img_mounted_sd = 1'b0;
      fdc_enable = 1'b0;
      img_size = 64'd0;
      sd_sck_core = 1'b0;
      sd_mosi_core = 1'b0;
      sd_miso_pin = 1'b0;
      vsd_miso = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index = 16'd0;
      motor = 1'b1;
      cas_dout = 1'b0;
      tape_adc = 1'b0;
      tape_adc_act = 1'b0;
      ddr_addr_download = '0;
      ddr_rd_download = 1'b0;
      ddr_request_download = 1'b0;
      ddr_addr_cas = '0;
      ddr_rd_cas = 1'b0;
      forced_scandoubler = 1'b0;
      hdmi_width = 12'd1280;
      hdmi_height = 12'd720;
      ocm_mode = 1'b0;
      cart_a_type = 4'd0;
      rom_a_load_hide = 1'b0;
      rom_b_load_hide = 1'b0;
      fdd_present = 6'd0;
      sram_size_0 = 16'd0;
      sram_size_1 = 16'd0;
      sram_size_2 = 16'd0;
      sram_size_3 = 16'd0;
      error_code = 8'd0;
      next_cycle(16);
      rst = 1'b0;
      next_cycle(1);
      check("led_user", led_user, 1'b0);
      check("led_disk", led_disk, 2'b10);
      check("sd_cs", sd_cs, 1'b0);
      check("cas_enable", cas_enable, 1'b0);
      check("crop_size", crop_size, 0);
      test_reset_sources();
      test_video_scaling();
      test_sd_routing();
      test_cassette();
      test_menu_mask();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/core_glue_asserts.sv ====
/* Protocol checks on the core glue top level, attached by bind.
   Covers SD pin gating, the play strobe and the info request */
`timescale 1ns/1ps
`default_nettype none

module core_glue_asserts (
   input logic       clock_bus,
   input logic       rst,
   input logic       sd_cs,
   input logic       sd_sck,
   input logic       sd_mosi,
   input logic       play,
   input logic       motor,
   input logic [7:0] info,
   input logic       info_req
);

   // Physical pins stay quiet while the virtual card is selected
   sd_pins_gated : assert property (@(posedge clock_bus) disable iff (rst)
      sd_cs |-> (!sd_sck && !sd_mosi))
      else $error("sd_sck or sd_mosi active while sd_cs is high");

   // Motor line is active low
   play_needs_motor : assert property (@(posedge clock_bus) disable iff (rst)
      play |-> !motor)
      else $error("play high while motor is high");

   info_req_matches : assert property (@(posedge clock_bus) disable iff (rst)
      info_req == (info != 8'd0))
      else $error("info_req does not match a nonzero info code");

endmodule

bind core_glue core_glue_asserts asserts_0 (
   .clock_bus (clock_bus),
   .rst       (rst),
   .sd_cs     (sd_cs),
   .sd_sck    (sd_sck),
   .sd_mosi   (sd_mosi),
   .play      (play),
   .motor     (motor),
   .info      (info),
   .info_req  (info_req)
);

`default_nettype wire

// ==== hdl/core_glue.sv ====
/* Top level of the core glue logic. Connects status decode, SD routing,
   cassette control, video scaling and the menu mask by name */
`timescale 1ns/1ps
`default_nettype none

module core_glue (
   input  logic                                     clock_bus,
   input  logic                                     rst,
   // Menu and resets
   input  logic [core_glue_pkg::status_width-1:0]   status,
   input  logic                                     upload_reset,
   input  logic                                     img_mounted_sd,
   input  logic                                     fdc_enable,
   output logic                                     core_hard_reset,
   output logic                                     core_reset,
   output logic                                     sram_save,
   output logic                                     sram_load,
   // SD card
   input  logic [63:0]                              img_size,
   input  logic                                     sd_sck_core,
   input  logic                                     sd_mosi_core,
   input  logic                                     sd_miso_pin,
   input  logic                                     vsd_miso,
   output logic                                     sd_miso_core,
   output logic                                     sd_cs,
   output logic                                     sd_sck,
   output logic                                     sd_mosi,
   output logic                                     led_user,
   output logic [1:0]                               led_disk,
   // Cassette
   input  logic                                     ioctl_download,
   input  logic [15:0]                              ioctl_index,
   input  logic                                     motor,
   input  logic                                     cas_dout,
   input  logic                                     tape_adc,
   input  logic                                     tape_adc_act,
   input  logic [core_glue_pkg::ddr_addr_width-1:0] ddr_addr_download,
   input  logic                                     ddr_rd_download,
   input  logic                                     ddr_request_download,
   input  logic [core_glue_pkg::ddr_addr_width-1:0] ddr_addr_cas,
   input  logic                                     ddr_rd_cas,
   output logic                                     tape_in,
   output logic                                     play,
   output logic                                     rewind,
   output logic                                     cas_enable,
   output logic [core_glue_pkg::ddr_addr_width-1:0] ddr_addr,
   output logic                                     ddr_rd,
   // Video
   input  logic                                     forced_scandoubler,
   input  logic [11:0]                              hdmi_width,
   input  logic [11:0]                              hdmi_height,
   output logic [1:0]                               vga_sl,
   output logic                                     scandoubler,
   output logic                                     hq2x,
   output logic [11:0]                              arx,
   output logic [11:0]                              ary,
   output logic [11:0]                              crop_size,
   output logic [2:0]                               scale,
   // Menu mask
   input  logic                                     ocm_mode,
   input  logic [3:0]                               cart_a_type,
   input  logic                                     rom_a_load_hide,
   input  logic                                     rom_b_load_hide,
   input  logic [5:0]                               fdd_present,
   input  logic [15:0]                              sram_size_0,
   input  logic [15:0]                              sram_size_1,
   input  logic [15:0]                              sram_size_2,
   input  logic [15:0]                              sram_size_3,
   input  logic [7:0]                               error_code,
   output logic [15:0]                              menu_mask,
   output logic [7:0]                               info,
   output logic                                     info_req
);

   // Decoded menu fields
   logic [1:0] aspect;
   logic [2:0] scaler_fx;
   logic [2:0] scale_mode;
   logic       tape_adc_sel;
   logic       rewind_req;

   // Ports share names with the nets above
   status_decode decode_0 (.*);

   sd_activity sd_0 (.*);

   tape_control tape_0 (.*);

   video_scaling video_0 (.*);

   osd_menu_mask menu_0 (.*);

endmodule

`default_nettype wire

// ==== hdl/osd_menu_mask.sv ====
/* Menu-hide mask for the on-screen menu and the error info request */
`timescale 1ns/1ps
`default_nettype none

module osd_menu_mask (
   input  logic        ocm_mode,
   input  logic [3:0]  cart_a_type,
   input  logic        rom_a_load_hide,
   input  logic        rom_b_load_hide,
   input  logic [5:0]  fdd_present,
   input  logic [15:0] sram_size_0,
   input  logic [15:0] sram_size_1,
   input  logic [15:0] sram_size_2,
   input  logic [15:0] sram_size_3,
   input  logic        tape_adc_sel,
   input  logic [7:0]  error_code,
   output logic [15:0] menu_mask,
   output logic [7:0]  info,
   output logic        info_req
);
   import core_glue_pkg::*;

   // Wide enough that four sizes cannot wrap to zero
   logic [17:0] sram_total;

   assign sram_total = 18'(sram_size_0) + 18'(sram_size_1)
                     + 18'(sram_size_2) + 18'(sram_size_3);

   // ====================
   // Mask bits, a set bit hides the entry
   assign menu_mask[0]     = ocm_mode | (cart_a_type == cart_type_mfrsd);
   assign menu_mask[1]     = rom_a_load_hide | ocm_mode;
   assign menu_mask[2]     = rom_b_load_hide | ocm_mode;
   assign menu_mask[3]     = ocm_mode;
   assign menu_mask[9:4]   = fdd_present;
   assign menu_mask[10]    = (sram_total == 18'd0);
   assign menu_mask[11]    = tape_adc_sel;
   assign menu_mask[15:12] = 4'd0;

   assign info     = error_code;
   assign info_req = (error_code != err_none);

endmodule

`default_nettype wire

// ==== hdl/video_scaling.sv ====
/* Video scaler settings. Aspect ratio, scanline level, scandoubler
   flags and the 216-line crop used on a 1920x1080 output */
`timescale 1ns/1ps
`default_nettype none

module video_scaling (
   input  logic        clock_bus,
   input  logic        rst,
   input  logic [1:0]  aspect,
   input  logic [2:0]  scaler_fx,
   input  logic [2:0]  scale_mode,
   input  logic        forced_scandoubler,
   input  logic [11:0] hdmi_width,
   input  logic [11:0] hdmi_height,
   output logic [1:0]  vga_sl,
   output logic        scandoubler,
   output logic        hq2x,
   output logic [11:0] arx,
   output logic [11:0] ary,
   output logic [11:0] crop_size,
   output logic [2:0]  scale
);
   import core_glue_pkg::*;

   logic       en216p;

   // Aspect 0 is the native 4:3, others select a custom ratio slot
   assign arx = (aspect == 2'd0) ? aspect_w : {10'd0, aspect - 2'd1};
   assign ary = (aspect == 2'd0) ? aspect_h : 12'd0;

   // Effect 1 is hq2x, 2 and up are scanline levels
   assign vga_sl      = (scaler_fx != 3'd0) ? scaler_fx[1:0] - 2'd1 : 2'd0;
   assign scandoubler = forced_scandoubler | (scaler_fx != 3'd0);
   assign hq2x        = (scaler_fx == 3'd1);
   assign scale       = scale_mode;

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         en216p <= 1'b0;
      end else begin
         en216p <= (hdmi_width == hdmi_full_w) && (hdmi_height == hdmi_full_h)
                   && !scandoubler;
      end
   end

   assign crop_size = en216p ? crop_216 : 12'd0;

endmodule

`default_nettype wire

// ==== hdl/tape_control.sv ====
/* Cassette control. Detects a finished cassette download, drives the
   play and rewind strobes and muxes the tape input and memory requests */
`timescale 1ns/1ps
`default_nettype none

module tape_control (
   input  logic                                     clock_bus,
   input  logic                                     rst,
   input  logic                                     core_reset,
   input  logic                                     rewind_req,
   input  logic                                     tape_adc_sel,
   input  logic                                     ioctl_download,
   input  logic [15:0]                              ioctl_index,
   input  logic                                     motor,
   input  logic                                     cas_dout,
   input  logic                                     tape_adc,
   input  logic                                     tape_adc_act,
   input  logic [core_glue_pkg::ddr_addr_width-1:0] ddr_addr_download,
   input  logic                                     ddr_rd_download,
   input  logic                                     ddr_request_download,
   input  logic [core_glue_pkg::ddr_addr_width-1:0] ddr_addr_cas,
   input  logic                                     ddr_rd_cas,
   output logic                                     tape_in,
   output logic                                     play,
   output logic                                     rewind,
   output logic                                     cas_enable,
   output logic [core_glue_pkg::ddr_addr_width-1:0] ddr_addr,
   output logic                                     ddr_rd
);
   import core_glue_pkg::*;

   logic cas_download;
   logic cas_download_q;
   logic cas_load;

   assign cas_download = ioctl_download & (ioctl_index[5:0] == cas_ioctl_index);

   // Cassette becomes playable once its download has ended
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         cas_download_q <= 1'b0;
         cas_load       <= 1'b0;
      end else begin
         cas_download_q <= cas_download;
         if (cas_download_q & ~cas_download) begin
            cas_load <= 1'b1;
         end
      end
   end

   assign cas_enable = cas_load;
   // Motor line is active low
   assign play       = ~motor & cas_load;
   assign rewind     = rewind_req | cas_download | core_reset;
   assign tape_in    = tape_adc_sel ? (tape_adc & tape_adc_act) : cas_dout;

   // ROM download has priority over cassette playback
   assign ddr_addr = ddr_request_download ? ddr_addr_download : ddr_addr_cas;
   assign ddr_rd   = ddr_request_download ? ddr_rd_download : ddr_rd_cas;

endmodule

`default_nettype wire

// ==== hdl/sd_activity.sv ====
/* SD card routing between the virtual image and the physical slot,
   plus the activity timer that lights the user and disk LEDs */
`timescale 1ns/1ps
`default_nettype none

module sd_activity (
   input  logic        clock_bus,
   input  logic        rst,
   input  logic        img_mounted_sd,
   input  logic [63:0] img_size,
   input  logic        sd_sck_core,
   input  logic        sd_mosi_core,
   input  logic        sd_miso_pin,
   input  logic        vsd_miso,
   output logic        sd_miso_core,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        led_user,
   output logic [1:0]  led_disk
);
   import core_glue_pkg::*;

   logic                    vsd_sel;
   logic                    sd_act;
   logic [sd_act_width-1:0] act_timer;
   logic                    old_mosi;
   logic                    old_miso;
   logic                    pin_change;

   // A mounted image with data selects the virtual card
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_sd) begin
         vsd_sel <= |img_size;
      end
   end

   // ====================
   // Pin routing
   assign sd_miso_core = vsd_sel ? vsd_miso : sd_miso_pin;
   assign sd_cs        = vsd_sel;
   assign sd_sck       = sd_sck_core & ~vsd_sel;
   assign sd_mosi      = sd_mosi_core & ~vsd_sel;

   // ====================
   // Activity timer
   always_ff @(posedge clock_bus) begin
      old_mosi <= sd_mosi_core;
      old_miso <= sd_miso_core;
   end

   assign pin_change = (old_mosi ^ sd_mosi_core) | (old_miso ^ sd_miso_core);

   // Timer saturates at sd_act_cycles, light is on below that
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         act_timer <= sd_act_cycles;
         sd_act    <= 1'b0;
      end else begin
         if (pin_change) begin
            act_timer <= '0;
         end else if (act_timer < sd_act_cycles) begin
            act_timer <= act_timer + 1'b1;
         end
         sd_act <= (act_timer < sd_act_cycles);
      end
   end

   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

`default_nettype wire

// ==== hdl/status_decode.sv ====
/* Splits the menu status word into its option fields and builds the
   hard reset and the core reset levels */
`timescale 1ns/1ps
`default_nettype none

module status_decode (
   input  logic                                   clock_bus,
   input  logic                                   rst,
   input  logic [core_glue_pkg::status_width-1:0] status,
   input  logic                                   upload_reset,
   input  logic                                   img_mounted_sd,
   input  logic                                   fdc_enable,
   output logic                                   core_hard_reset,
   output logic                                   core_reset,
   output logic [1:0]                             aspect,
   output logic [2:0]                             scaler_fx,
   output logic [2:0]                             scale_mode,
   output logic                                   tape_adc_sel,
   output logic                                   rewind_req,
   output logic                                   sram_save,
   output logic                                   sram_load
);
   import core_glue_pkg::*;

   logic mount_reset;

   // ====================
   // Option fields
   assign aspect       = status[st_ar_lo +: 2];
   assign scaler_fx    = status[st_scaler_lo +: 3];
   assign scale_mode   = status[st_scale_lo +: 3];
   assign tape_adc_sel = status[st_tape_adc];
   assign rewind_req   = status[st_tape_rewind];
   assign sram_save    = status[st_sram_save];
   assign sram_load    = status[st_sram_load];

   // ====================
   // Resets

   // Hard reset also wipes the loaded configuration
   assign core_hard_reset = rst | status[st_reset] | upload_reset;

   // Reset after mount only matters with the floppy controller present
   assign mount_reset = status[st_reset_mount] & img_mounted_sd & fdc_enable;

   assign core_reset = core_hard_reset
                     | status[st_detach]
                     | status[st_reset_osd]
                     | mount_reset;

endmodule

`default_nettype wire

// ==== hdl/core_glue_pkg.sv ====
/* Constants shared by the core glue logic. Menu status bit positions,
   cartridge and error codes, counter widths and video sizes */
`default_nettype none

package core_glue_pkg;

   // ====================
   // Menu status word
   localparam int status_width   = 48;
   localparam int st_reset       = 0;
   localparam int st_ar_lo       = 1;
   localparam int st_scaler_lo   = 3;
   localparam int st_scale_lo    = 6;
   localparam int st_tape_rewind = 9;
   localparam int st_detach      = 10;
   localparam int st_reset_mount = 12;
   localparam int st_reset_osd   = 21;
   localparam int st_sram_save   = 38;
   localparam int st_sram_load   = 39;
   localparam int st_tape_adc    = 40;

   // ====================
   // Loader and cartridge codes

   // Slot A type that owns the SD card entry of the menu
   localparam logic [3:0] cart_type_mfrsd = 4'd9;
   localparam logic [5:0] cas_ioctl_index = 6'd5;
   localparam logic [7:0] err_none        = 8'd0;

   // ====================
   // SD activity light
   localparam int sd_act_width = 20;
   localparam logic [sd_act_width-1:0] sd_act_cycles = 20'd1000000;

   // Memory request address
   localparam int ddr_addr_width = 28;

   // ====================
   // Video output
   localparam logic [11:0] crop_216    = 12'd216;
   localparam logic [11:0] hdmi_full_w = 12'd1920;
   localparam logic [11:0] hdmi_full_h = 12'd1080;
   localparam logic [11:0] aspect_w    = 12'd4;
   localparam logic [11:0] aspect_h    = 12'd3;

endpackage

`default_nettype wire
